/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= zynq_bridge_tb
FLIST     ?= verilog.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= sim_$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* verilog.f */
+incdir+.
zynq_bridge_pkg.sv
zynq_config_rom.sv
zynq_bridge_fifo.sv
zynq_dram_xlate.sv
zynq_csr_regs.sv
zynq_bridge_top.sv
zynq_bridge_sva.sv
zynq_bridge_tb.sv

/* zynq_bridge_config.svh */
`ifndef ZYNQ_BRIDGE_CONFIG_SVH
`define ZYNQ_BRIDGE_CONFIG_SVH

// host side
`define ZB_DATA_WIDTH          32
`define ZB_CSR_ADDR_WIDTH      3

// last level cache and dram window
`define ZB_NUM_CACHE           8
`define ZB_LG_NUM_CACHE        3
`define ZB_LLC_ADDR_WIDTH      28
`define ZB_DRAM_ADDR_WIDTH     27
`define ZB_DRAM_ADDR_WIDTH_OUT 32

// core side
`define ZB_RESET_DEPTH         3
`define ZB_DMA_FIFO_ELS        4
`define ZB_ROM_ELS             8
`define ZB_ROM_ADDR_WIDTH      3
`define ZB_VERSION             32'h0001_0300

// register map
`define ZB_CSR_RESET           0
`define ZB_CSR_DRAM_BASE       1
`define ZB_CSR_ROM_ADDR        2
`define ZB_CSR_ROM_DATA        3
`define ZB_CSR_CMD_COUNT       4

`endif

/* zynq_bridge_fifo.sv */
module zynq_bridge_fifo
  #(parameter type payload_t = logic
  , parameter int  ELS       = 4
  )
  (input  logic     aclk
  , input  logic    rst_i
  , input  payload_t data_i
  , input  logic    v_i
  , output logic    ready_o
  , output payload_t data_o
  , output logic    v_o
  , input  logic    yumi_i
  );

  localparam int ptr_width_lp = (ELS > 1) ? $clog2(ELS) : 1;
  localparam int cnt_width_lp = $clog2(ELS + 1);

  payload_t                  mem_r [ELS];
  logic [ptr_width_lp-1:0]   wr_ptr_r, rd_ptr_r;
  logic [cnt_width_lp-1:0]   count_r, count_n;
  logic                      push, pop;

  assign push = v_i & ready_o;
  assign pop  = yumi_i;

  assign count_n = count_r + cnt_width_lp'(push) - cnt_width_lp'(pop);

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      ready_o  <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(ELS-1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(ELS-1)) ? '0 : rd_ptr_r + 1'b1;
      count_r <= count_n;
      // full once the next count reaches ELS
      ready_o <= (count_n != cnt_width_lp'(ELS));
    end
  end

  always_ff @(posedge aclk)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

  assign data_o = mem_r[rd_ptr_r];
  assign v_o    = (count_r != '0);

endmodule

/* zynq_bridge_pkg.sv */
`include "zynq_bridge_config.svh"

package zynq_bridge_pkg;

  // single beat host register access
  typedef struct packed
  {
    logic                          write;
    logic [`ZB_CSR_ADDR_WIDTH-1:0] addr;
    logic [`ZB_DATA_WIDTH-1:0]     data;
  } host_req_t;

  // control values driven out of the register file
  typedef struct packed
  {
    logic [`ZB_DRAM_ADDR_WIDTH_OUT-1:0] dram_base;
    logic [`ZB_ROM_ADDR_WIDTH-1:0]      rom_addr;
  } csr_ctl_t;

  // dma request from one cache
  typedef struct packed
  {
    logic                          write;
    logic [`ZB_LG_NUM_CACHE-1:0]   cache_id;
    logic [`ZB_LLC_ADDR_WIDTH-1:0] addr;
  } dma_req_t;

  // command toward dram
  typedef struct packed
  {
    logic                               write;
    logic [`ZB_DRAM_ADDR_WIDTH_OUT-1:0] addr;
  } dram_cmd_t;

endpackage

/* zynq_bridge_sva.sv */
module zynq_bridge_sva
  (input  logic                         aclk
  , input  logic                        rst_i
  , input  zynq_bridge_pkg::host_req_t  host_req_i
  , input  logic                        host_req_v_i
  , input  logic                        host_rsp_v_i
  , input  zynq_bridge_pkg::dram_cmd_t  dram_cmd_i
  , input  logic                        dram_cmd_v_i
  , input  logic                        dram_cmd_ready_i
  , input  logic                        core_rst_i
  );

  // command held while the dram side stalls
  cmd_stable_a: assert property (@(posedge aclk) disable iff (rst_i || core_rst_i)
    dram_cmd_v_i && !dram_cmd_ready_i |=> $stable(dram_cmd_i))
    else $error("dram command changed while stalled");

  // fifo is cleared one edge after core reset is seen
  no_cmd_in_reset_a: assert property (@(posedge aclk) disable iff (rst_i)
    core_rst_i |=> !dram_cmd_v_i)
    else $error("dram command valid during core reset");

  rsp_after_read_a: assert property (@(posedge aclk) disable iff (rst_i)
    host_req_v_i && !host_req_i.write |=> host_rsp_v_i)
    else $error("no host response one cycle after read");

endmodule

bind zynq_bridge_top zynq_bridge_sva sva
  (.aclk(aclk), .rst_i(rst_i)
   ,.host_req_i(host_req_i), .host_req_v_i(host_req_v_i), .host_rsp_v_i(host_rsp_v_o)
   ,.dram_cmd_i(dram_cmd_o), .dram_cmd_v_i(dram_cmd_v_o)
   ,.dram_cmd_ready_i(dram_cmd_ready_i), .core_rst_i(core_rst_o)
   );

/* zynq_bridge_tb.sv */
`include "zynq_bridge_config.svh"

module zynq_bridge_tb;

  localparam int          num_vec_lp    = 12;
  localparam int          wait_limit_lp = 200;
  localparam logic [31:0] lfsr_taps_lp  = 32'h8020_0003;
  localparam logic [31:0] xlate_base_lp = 32'hf900_0000;

  logic                         aclk, rst_i, host_req_v_i, host_rsp_v_o;
  logic                         dma_req_v_i, dma_req_ready_o, dram_cmd_v_o;
  logic                         dram_cmd_ready_i, core_rst_o;
  logic [`ZB_DATA_WIDTH-1:0]    host_rsp_o;
  zynq_bridge_pkg::host_req_t   host_req_i;
  zynq_bridge_pkg::dma_req_t    dma_req_i;
  zynq_bridge_pkg::dram_cmd_t   dram_cmd_o;

  zynq_bridge_pkg::dma_req_t    req_tab [num_vec_lp];
  zynq_bridge_pkg::dram_cmd_t   exp_tab [num_vec_lp];
  logic [31:0]                  rom_tab [`ZB_ROM_ELS];
  logic [31:0]                  lfsr_state;
  logic                         drained;
  int                           a;

  zynq_bridge_top DUT
    (.aclk(aclk), .rst_i(rst_i)
     ,.host_req_i(host_req_i), .host_req_v_i(host_req_v_i)
     ,.host_rsp_o(host_rsp_o), .host_rsp_v_o(host_rsp_v_o)
     ,.dma_req_i(dma_req_i), .dma_req_v_i(dma_req_v_i), .dma_req_ready_o(dma_req_ready_o)
     ,.dram_cmd_o(dram_cmd_o), .dram_cmd_v_o(dram_cmd_v_o)
     ,.dram_cmd_ready_i(dram_cmd_ready_i), .core_rst_o(core_rst_o)
     );

  always #20 aclk = ~aclk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ lfsr_taps_lp;
    return state >> 1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  endtask

  // expected addresses worked out by hand for a base of f900_0000
  task automatic add_vec(input int idx, input logic wr, input logic [2:0] id,
                         input logic [27:0] addr, input logic [31:0] exp_addr);
    req_tab[idx] = '{write: wr, cache_id: id, addr: addr};
    exp_tab[idx] = '{write: wr, addr: exp_addr};
  endtask

  task automatic load_tables();
    add_vec(0,  1'b0, 3'd0, 28'h000_0000, 32'hf900_0000);
    add_vec(1,  1'b1, 3'd1, 28'h000_0040, 32'hfa00_0040);
    add_vec(2,  1'b0, 3'd2, 28'hf12_3450, 32'hfb12_3450);
    add_vec(3,  1'b1, 3'd3, 28'h0ff_ffc0, 32'hfcff_ffc0);
    add_vec(4,  1'b0, 3'd4, 28'h5a5_a5a0, 32'hfda5_a5a0);
    add_vec(5,  1'b1, 3'd5, 28'h000_0008, 32'hfe00_0008);
    add_vec(6,  1'b0, 3'd6, 28'h3c0_ffe0, 32'hffc0_ffe0);
    // these two wrap past 2^32
    add_vec(7,  1'b1, 3'd7, 28'h000_0100, 32'h0000_0100);
    add_vec(8,  1'b0, 3'd7, 28'hfff_ffff, 32'h00ff_ffff);
    add_vec(9,  1'b1, 3'd0, 28'h8ab_cde0, 32'hf9ab_cde0);
    add_vec(10, 1'b0, 3'd3, 28'h100_0020, 32'hfc00_0020);
    add_vec(11, 1'b1, 3'd6, 28'h765_4321, 32'hff65_4321);
    rom_tab = '{`ZB_VERSION, 32'd8, 32'd27, 32'd3, 32'd4, 32'd0, 32'd0, 32'd0};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host port

  task automatic host_write(input logic [`ZB_CSR_ADDR_WIDTH-1:0] reg_addr,
                            input logic [31:0] data);
    @(posedge aclk);
    host_req_v_i <= 1'b1;
    host_req_i   <= '{write: 1'b1, addr: reg_addr, data: data};
    @(posedge aclk);
    host_req_v_i <= 1'b0;
  endtask

  task automatic expect_reg(input logic [`ZB_CSR_ADDR_WIDTH-1:0] reg_addr,
                            input logic [31:0] exp);
    int waited;
    @(posedge aclk);
    host_req_v_i <= 1'b1;
    host_req_i   <= '{write: 1'b0, addr: reg_addr, data: '0};
    @(posedge aclk);
    host_req_v_i <= 1'b0;
    waited = 0;
    @(negedge aclk);
    while (!host_rsp_v_o)
    begin
      waited++;
      if (waited > wait_limit_lp)
        report_timeout("host read response");
      @(negedge aclk);
    end
    check_value("host_rsp_o", 64'(host_rsp_o), 64'(exp));
  endtask

  // core_rst_o follows register 0 after exactly ZB_RESET_DEPTH edges
  task automatic check_reset_chain(input logic new_val);
    int   c;
    logic exp_rst;
    host_write(`ZB_CSR_RESET, 32'(new_val));
    for (c = 0; c <= `ZB_RESET_DEPTH; c++)
    begin
      @(negedge aclk);
      exp_rst = (c < `ZB_RESET_DEPTH) ? !new_val : new_val;
      check_value("core_rst_o", 64'(core_rst_o), 64'(exp_rst));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // dma and dram sides

  task automatic push_all();
    int i;
    int waited;
    @(posedge aclk);
    for (i = 0; i < num_vec_lp; i++)
    begin
      dma_req_v_i <= 1'b1;
      dma_req_i   <= req_tab[i];
      waited = 0;
      @(negedge aclk);
      while (!dma_req_ready_o)
      begin
        waited++;
        if (waited > wait_limit_lp)
          report_timeout("dma request ready");
        @(negedge aclk);
      end
      @(posedge aclk);
    end
    dma_req_v_i <= 1'b0;
  endtask

  task automatic collect_all();
    int i;
    int waited;
    for (i = 0; i < num_vec_lp; i++)
    begin
      waited = 0;
      @(negedge aclk);
      while (!(dram_cmd_v_o && dram_cmd_ready_i))
      begin
        waited++;
        if (waited > wait_limit_lp)
          report_timeout("dram command");
        @(negedge aclk);
      end
      check_value("dram_cmd_o.write", 64'(dram_cmd_o.write), 64'(exp_tab[i].write));
      check_value("dram_cmd_o.addr", 64'(dram_cmd_o.addr), 64'(exp_tab[i].addr));
    end
    drained = 1'b1;
  endtask

  // one lfsr bit per cycle decides the dram stall
  task automatic drive_backpressure();
    int cycles;
    cycles = 0;
    while (!drained)
    begin
      cycles++;
      if (cycles > num_vec_lp * wait_limit_lp)
        report_timeout("dram side to drain");
      @(posedge aclk);
      lfsr_state       = lfsr_step(lfsr_state);
      dram_cmd_ready_i <= lfsr_state[0];
    end
    dram_cmd_ready_i <= 1'b1;
  endtask

  initial
  begin
    aclk             = 1'b0;
    rst_i            = 1'b1;
    host_req_i       = '0;
    host_req_v_i     = 1'b0;
    dma_req_i        = '0;
    dma_req_v_i      = 1'b0;
    dram_cmd_ready_i = 1'b0;
    lfsr_state       = 32'hfe83;
    drained          = 1'b0;
    load_tables();
    repeat (10) @(posedge aclk);
    rst_i <= 1'b0;

    @(negedge aclk);
    check_value("core_rst_o", 64'(core_rst_o), 64'd1);
    check_value("dram_cmd_v_o", 64'(dram_cmd_v_o), 64'd0);
    check_value("dma_req_ready_o", 64'(dma_req_ready_o), 64'd0);
    expect_reg(`ZB_CSR_RESET, 32'd1);
    // command count is read only
    host_write(`ZB_CSR_CMD_COUNT, 32'hffff_ffff);
    expect_reg(`ZB_CSR_CMD_COUNT, 32'd0);

    host_write(`ZB_CSR_DRAM_BASE, 32'h1234_5678);
    host_write(`ZB_CSR_ROM_ADDR, 32'd5);
    expect_reg(`ZB_CSR_DRAM_BASE, 32'h1234_5678);
    expect_reg(`ZB_CSR_ROM_ADDR, 32'd5);
    for (a = 5; a < 8; a++)
      expect_reg(`ZB_CSR_ADDR_WIDTH'(a), 32'd0);

    for (a = 0; a < `ZB_ROM_ELS; a++)
    begin
      host_write(`ZB_CSR_ROM_ADDR, 32'(a));
      expect_reg(`ZB_CSR_ROM_DATA, rom_tab[a]);
    end

    check_reset_chain(1'b0);

    host_write(`ZB_CSR_DRAM_BASE, xlate_base_lp);
    fork
      push_all();
      collect_all();
      drive_backpressure();
    join
    expect_reg(`ZB_CSR_CMD_COUNT, 32'(num_vec_lp));

    check_reset_chain(1'b1);
    expect_reg(`ZB_CSR_CMD_COUNT, 32'd0);
    check_value("dram_cmd_v_o", 64'(dram_cmd_v_o), 64'd0);
    check_value("dma_req_ready_o", 64'(dma_req_ready_o), 64'd0);

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* zynq_bridge_top.sv */
`include "zynq_bridge_config.svh"

module zynq_bridge_top
  (input  logic                            aclk
  , input  logic                           rst_i
  , input  zynq_bridge_pkg::host_req_t     host_req_i
  , input  logic                           host_req_v_i
  , output logic [`ZB_DATA_WIDTH-1:0]      host_rsp_o
  , output logic                           host_rsp_v_o
  , input  zynq_bridge_pkg::dma_req_t      dma_req_i
  , input  logic                           dma_req_v_i
  , output logic                           dma_req_ready_o
  , output zynq_bridge_pkg::dram_cmd_t     dram_cmd_o
  , output logic                           dram_cmd_v_o
  , input  logic                           dram_cmd_ready_i
  , output logic                           core_rst_o
  );

  zynq_bridge_pkg::csr_ctl_t    csr_ctl_lo;
  zynq_bridge_pkg::dma_req_t    req_lo;
  zynq_bridge_pkg::dram_cmd_t   cmd_lo;
  logic [`ZB_DATA_WIDTH-1:0]    rom_data_lo, cmd_count_lo;
  logic                         core_reset;
  logic                         req_v_lo, req_yumi_lo, cmd_v_lo, cmd_ready_lo;

  ////////////////////////////////////////////////////////////////////////////
  // host control

  zynq_csr_regs csr
    (.aclk(aclk), .rst_i(rst_i)
     ,.host_req_i(host_req_i), .host_req_v_i(host_req_v_i)
     ,.rom_data_i(rom_data_lo), .cmd_count_i(cmd_count_lo)
     ,.host_rsp_o(host_rsp_o), .host_rsp_v_o(host_rsp_v_o)
     ,.csr_ctl_o(csr_ctl_lo), .core_rst_o(core_rst_o)
     );

  zynq_config_rom config_rom
    (.addr_i(csr_ctl_lo.rom_addr), .data_o(rom_data_lo));

  ////////////////////////////////////////////////////////////////////////////
  // dma to dram path

  assign core_reset = rst_i | core_rst_o;

  zynq_bridge_fifo #(.payload_t(zynq_bridge_pkg::dma_req_t), .ELS(`ZB_DMA_FIFO_ELS))
    dma_req_fifo
    (.aclk(aclk), .rst_i(core_reset)
     ,.data_i(dma_req_i), .v_i(dma_req_v_i), .ready_o(dma_req_ready_o)
     ,.data_o(req_lo), .v_o(req_v_lo), .yumi_i(req_yumi_lo)
     );

  zynq_dram_xlate xlate
    (.aclk(aclk), .rst_i(core_reset)
     ,.dma_req_i(req_lo), .dma_req_v_i(req_v_lo), .dma_req_yumi_o(req_yumi_lo)
     ,.dram_base_i(csr_ctl_lo.dram_base)
     ,.dram_cmd_o(cmd_lo), .v_o(cmd_v_lo), .ready_i(cmd_ready_lo)
     ,.cmd_count_o(cmd_count_lo)
     );

  zynq_bridge_fifo #(.payload_t(zynq_bridge_pkg::dram_cmd_t), .ELS(`ZB_DMA_FIFO_ELS))
    dram_cmd_fifo
    (.aclk(aclk), .rst_i(core_reset)
     ,.data_i(cmd_lo), .v_i(cmd_v_lo), .ready_o(cmd_ready_lo)
     ,.data_o(dram_cmd_o), .v_o(dram_cmd_v_o)
     ,.yumi_i(dram_cmd_v_o & dram_cmd_ready_i)
     );

endmodule

/* zynq_config_rom.sv */
`include "zynq_bridge_config.svh"

module zynq_config_rom
  (input  logic [`ZB_ROM_ADDR_WIDTH-1:0] addr_i
  , output logic [`ZB_DATA_WIDTH-1:0]    data_o
  );

  // machine description seen by host software
  always_comb
  begin
    case (addr_i)
      `ZB_ROM_ADDR_WIDTH'(0): data_o = `ZB_VERSION;
      `ZB_ROM_ADDR_WIDTH'(1): data_o = `ZB_DATA_WIDTH'(`ZB_NUM_CACHE);
      `ZB_ROM_ADDR_WIDTH'(2): data_o = `ZB_DATA_WIDTH'(`ZB_DRAM_ADDR_WIDTH);
      `ZB_ROM_ADDR_WIDTH'(3): data_o = `ZB_DATA_WIDTH'(`ZB_RESET_DEPTH);
      `ZB_ROM_ADDR_WIDTH'(4): data_o = `ZB_DATA_WIDTH'(`ZB_DMA_FIFO_ELS);
      // spare entries
      default:                data_o = '0;
    endcase
  end

endmodule

/* zynq_csr_regs.sv */
`include "zynq_bridge_config.svh"

module zynq_csr_regs
  (input  logic                           aclk
  , input  logic                          rst_i
  , input  zynq_bridge_pkg::host_req_t    host_req_i
  , input  logic                          host_req_v_i
  , input  logic [`ZB_DATA_WIDTH-1:0]     rom_data_i
  , input  logic [`ZB_DATA_WIDTH-1:0]     cmd_count_i
  , output logic [`ZB_DATA_WIDTH-1:0]     host_rsp_o
  , output logic                          host_rsp_v_o
  , output zynq_bridge_pkg::csr_ctl_t     csr_ctl_o
  , output logic                          core_rst_o
  );

  logic                            reset_r;
  zynq_bridge_pkg::csr_ctl_t       ctl_r;
  logic [`ZB_DATA_WIDTH-1:0]       rd_data;
  logic [`ZB_RESET_DEPTH-1:0]      rst_chain_r;

  //////////////////////////////////////////////////////////////////////////
  // host writes

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      reset_r         <= 1'b1;
      ctl_r.dram_base <= '0;
      ctl_r.rom_addr  <= '0;
    end
    else if (host_req_v_i && host_req_i.write)
    begin
      case (host_req_i.addr)
        `ZB_CSR_RESET:     reset_r         <= host_req_i.data[0];
        `ZB_CSR_DRAM_BASE: ctl_r.dram_base <= host_req_i.data;
        `ZB_CSR_ROM_ADDR:  ctl_r.rom_addr  <= host_req_i.data[`ZB_ROM_ADDR_WIDTH-1:0];
        // rom data and command count are read only
        default: ;
      endcase
    end
  end

  assign csr_ctl_o = ctl_r;

  //////////////////////////////////////////////////////////////////////////
  // host reads, answered one cycle later

  always_comb
  begin
    case (host_req_i.addr)
      `ZB_CSR_RESET:     rd_data = `ZB_DATA_WIDTH'(reset_r);
      `ZB_CSR_DRAM_BASE: rd_data = ctl_r.dram_base;
      `ZB_CSR_ROM_ADDR:  rd_data = `ZB_DATA_WIDTH'(ctl_r.rom_addr);
      `ZB_CSR_ROM_DATA:  rd_data = rom_data_i;
      `ZB_CSR_CMD_COUNT: rd_data = cmd_count_i;
      default:           rd_data = '0;
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
      host_rsp_v_o <= 1'b0;
    else
      host_rsp_v_o <= host_req_v_i & ~host_req_i.write;
  end

  always_ff @(posedge aclk)
  begin
    host_rsp_o <= rd_data;
  end

  //////////////////////////////////////////////////////////////////////////
  // core reset release

  // core side stays in reset until software clears bit 0
  always_ff @(posedge aclk)
  begin
    if (rst_i)
      rst_chain_r <= '1;
    else
      rst_chain_r <= {rst_chain_r[`ZB_RESET_DEPTH-2:0], reset_r};
  end

  assign core_rst_o = rst_chain_r[`ZB_RESET_DEPTH-1];

endmodule

/* zynq_dram_xlate.sv */
`include "zynq_bridge_config.svh"

module zynq_dram_xlate
  (input  logic                                aclk
  , input  logic                               rst_i
  , input  zynq_bridge_pkg::dma_req_t          dma_req_i
  , input  logic                               dma_req_v_i
  , output logic                               dma_req_yumi_o
  , input  logic [`ZB_DRAM_ADDR_WIDTH_OUT-1:0] dram_base_i
  , output zynq_bridge_pkg::dram_cmd_t         dram_cmd_o
  , output logic                               v_o
  , input  logic                               ready_i
  , output logic [`ZB_DATA_WIDTH-1:0]          cmd_count_o
  );

  // low cache address bits kept below the cache id
  localparam int offset_width_lp = `ZB_DRAM_ADDR_WIDTH - `ZB_LG_NUM_CACHE;

  logic [`ZB_DRAM_ADDR_WIDTH-1:0] addr_hash;
  logic                           take;

  assign take           = dma_req_v_i & (~v_o | ready_i);
  assign dma_req_yumi_o = take;

  assign addr_hash = {dma_req_i.cache_id, dma_req_i.addr[offset_width_lp-1:0]};

  always_ff @(posedge aclk)
  begin
    if (take)
    begin
      dram_cmd_o.write <= dma_req_i.write;
      dram_cmd_o.addr  <= `ZB_DRAM_ADDR_WIDTH_OUT'(addr_hash) + dram_base_i;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rst_i)
    begin
      v_o         <= 1'b0;
      cmd_count_o <= '0;
    end
    else
    begin
      v_o <= take | (v_o & ~ready_i);
      if (v_o & ready_i)
        cmd_count_o <= cmd_count_o + 1'b1;
    end
  end

endmodule
